// File: ctr_cipher_defs.svh
// Widths are tied together: CTR_DATA_WIDTH must be twice CTR_WIDTH, and rounds must be 1 to 8
`ifndef CTR_CIPHER_DEFS_SVH
`define CTR_CIPHER_DEFS_SVH

////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////

// Block counter width
`define CTR_WIDTH 16

// Data, key and keystream width, always twice the counter
`define CTR_DATA_WIDTH 32

////////////////////////////////////////////////////////////
// Keystream round function
////////////////////////////////////////////////////////////

// Rounds and pipeline stages, one per round
`define CTR_KS_ROUNDS 4

// Left rotate applied to each round sum
`define CTR_KS_ROT 5

`endif

// File: ctr_cipher_pkg.sv
// Types only; widths come from the defs header, which must be on the include path
`default_nettype none

`include "ctr_cipher_defs.svh"

package ctr_cipher_pkg;

    ////////////////////////////////////////////////////////////
    // Word types
    ////////////////////////////////////////////////////////////

    // Block counter value
    typedef logic [`CTR_WIDTH-1:0] ctr_t;

    // Data, key or keystream word
    typedef logic [`CTR_DATA_WIDTH-1:0] word_t;

    ////////////////////////////////////////////////////////////
    // Enumerations
    ////////////////////////////////////////////////////////////

    // Command opcodes, sampled with cmd_valid
    typedef enum logic [1:0] {
        CMD_NOP      = 2'd0,
        CMD_LOAD     = 2'd1,
        CMD_PROCESS  = 2'd2,
        CMD_RESERVED = 2'd3
    } cmd_e;

    // Counter unit state, ready once a counter has been loaded
    typedef enum logic {
        ST_UNLOADED = 1'b0,
        ST_READY    = 1'b1
    } ctr_state_e;

endpackage

`default_nettype wire

// File: ctr_counter_unit.sv
// No back-pressure: a valid CMD_PROCESS issues a block the next cycle; err is sticky until reset
`timescale 1ns/1ps
`default_nettype none

`include "ctr_cipher_defs.svh"

module ctr_counter_unit import ctr_cipher_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  cmd_valid,
    input  cmd_e  cmd,
    input  ctr_t  init_ctr,
    input  word_t data_in,
    input  word_t key,
    output logic  blk_valid,
    output ctr_t  blk_ctr,
    output word_t blk_key,
    output word_t blk_data,
    output logic  err
);

    ctr_state_e state_q;
    ctr_t       ctr_q;
    logic       load;
    logic       issue;
    logic       err_set;

    ////////////////////////////////////////////////////////////
    // Command decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        load    = 1'b0;
        issue   = 1'b0;
        err_set = 1'b0;
        if (cmd_valid) begin
            case (cmd)
                CMD_NOP: begin
                    // Idle slot
                end
                CMD_LOAD: load = 1'b1;
                CMD_PROCESS: begin
                    // Block before any load is dropped
                    if (state_q == ST_READY) begin
                        issue = 1'b1;
                    end else begin
                        err_set = 1'b1;
                    end
                end
                default: err_set = 1'b1;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // State, counter and flags
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= ST_UNLOADED;
            ctr_q     <= '0;
            blk_valid <= 1'b0;
            err       <= 1'b0;
        end else begin
            blk_valid <= issue;
            // Reload also allowed when already ready
            if (load) begin
                ctr_q   <= init_ctr;
                state_q <= ST_READY;
            end else if (issue) begin
                // Wraps from all ones to zero
                ctr_q <= ctr_q + ctr_t'(1);
            end
            if (err_set) begin
                err <= 1'b1;
            end
        end
    end

    // Issued block payload, counter taken before the increment
    always_ff @(posedge clk) begin
        if (issue) begin
            blk_ctr  <= ctr_q;
            blk_key  <= key;
            blk_data <= data_in;
        end
    end

    // No block may come out of a cycle spent unloaded
    a_no_blk_unloaded: assert property (@(posedge clk) disable iff (reset)
        (state_q == ST_UNLOADED) |=> !blk_valid);

    // Error flag holds until reset
    a_err_sticky: assert property (@(posedge clk) disable iff (reset)
        err |=> err);

endmodule

`default_nettype wire

// File: ctr_keystream.sv
// Latency is exactly CTR_KS_ROUNDS cycles with one block per stage; only the valids are reset
`timescale 1ns/1ps
`default_nettype none

`include "ctr_cipher_defs.svh"

module ctr_keystream import ctr_cipher_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  blk_valid,
    input  ctr_t  blk_ctr,
    input  word_t blk_key,
    input  word_t blk_data,
    output logic  ks_valid,
    output word_t ks_word,
    output word_t ks_data
);

    // Index 0 is the stage input, index N the output of round N-1
    logic  st_valid [0:`CTR_KS_ROUNDS];
    word_t st_state [0:`CTR_KS_ROUNDS];
    // Key only goes as far as the last round input
    word_t st_key   [0:`CTR_KS_ROUNDS-1];
    word_t st_data  [0:`CTR_KS_ROUNDS];

    function automatic word_t rotl(input word_t x, input int unsigned n);
        return (x << n) | (x >> (`CTR_DATA_WIDTH - n));
    endfunction

    function automatic word_t rotr(input word_t x, input int unsigned n);
        return (x >> n) | (x << (`CTR_DATA_WIDTH - n));
    endfunction

    // Catch macro values the datapath cannot handle
    if (`CTR_DATA_WIDTH != 2 * `CTR_WIDTH) begin : g_width_check
        $error("CTR_DATA_WIDTH must be twice CTR_WIDTH");
    end
    if (`CTR_KS_ROUNDS < 1 || `CTR_KS_ROUNDS > 8) begin : g_round_check
        $error("CTR_KS_ROUNDS must be 1 to 8");
    end

    ////////////////////////////////////////////////////////////
    // Initial state
    ////////////////////////////////////////////////////////////

    // Counter on top, its inverse below
    assign st_valid[0] = blk_valid;
    assign st_state[0] = {blk_ctr, ~blk_ctr};
    assign st_key[0]   = blk_key;
    assign st_data[0]  = blk_data;

    ////////////////////////////////////////////////////////////
    // Round stages
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `CTR_KS_ROUNDS; i++) begin : g_round
        // Key rotates right by a byte more each round
        localparam int unsigned KEY_ROT = (8 * i) % `CTR_DATA_WIDTH;

        word_t sum;
        word_t mixed;

        // Add, rotate, xor
        assign sum   = st_state[i] + st_key[i];
        assign mixed = rotl(sum, `CTR_KS_ROT) ^ rotr(st_key[i], KEY_ROT);

        always_ff @(posedge clk) begin
            if (reset) begin
                st_valid[i+1] <= 1'b0;
            end else begin
                st_valid[i+1] <= st_valid[i];
            end
        end

        // Data rides alongside the state
        always_ff @(posedge clk) begin
            st_state[i+1] <= mixed;
            st_data[i+1]  <= st_data[i];
        end

        // Key moves on to the next round, the last round has none
        if (i < `CTR_KS_ROUNDS - 1) begin : g_key_carry
            always_ff @(posedge clk) begin
                st_key[i+1] <= st_key[i];
            end
        end
    end

    assign ks_valid = st_valid[`CTR_KS_ROUNDS];
    assign ks_word  = st_state[`CTR_KS_ROUNDS];
    assign ks_data  = st_data[`CTR_KS_ROUNDS];

    // Fixed latency, no stage ever drops or adds a block
    a_ks_latency: assert property (@(posedge clk) disable iff (reset)
        ks_valid == $past(blk_valid, `CTR_KS_ROUNDS));

endmodule

`default_nettype wire

// File: ctr_combiner.sv
// data_out holds the last result between strobes and is unknown before the first one
`timescale 1ns/1ps
`default_nettype none

`include "ctr_cipher_defs.svh"

module ctr_combiner import ctr_cipher_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  ks_valid,
    input  word_t ks_word,
    input  word_t ks_data,
    output word_t data_out,
    output logic  data_valid
);

    word_t mixed;

    // Same operation both ways
    assign mixed = ks_data ^ ks_word;

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    // One-cycle strobe per result
    always_ff @(posedge clk) begin
        if (reset) begin
            data_valid <= 1'b0;
        end else begin
            data_valid <= ks_valid;
        end
    end

    // Result only loads on a valid word
    always_ff @(posedge clk) begin
        if (ks_valid) begin
            data_out <= mixed;
        end
    end

    // Strobe must be clean once out of reset
    a_valid_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(data_valid));

endmodule

`default_nettype wire

// File: ctr_cipher_top.sv
// Sink must take one result per cycle; data_valid follows a CMD_PROCESS by CTR_KS_ROUNDS + 2
`timescale 1ns/1ps
`default_nettype none

`include "ctr_cipher_defs.svh"

module ctr_cipher_top import ctr_cipher_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  cmd_valid,
    input  cmd_e  cmd,
    input  ctr_t  init_ctr,
    input  word_t data_in,
    input  word_t key,
    output word_t data_out,
    output logic  data_valid,
    output logic  err
);

    // Counter unit to keystream
    logic  blk_valid;
    ctr_t  blk_ctr;
    word_t blk_key;
    word_t blk_data;

    // Keystream to combiner
    logic  ks_valid;
    word_t ks_word;
    word_t ks_data;

    ////////////////////////////////////////////////////////////
    // Command decode and block issue
    ////////////////////////////////////////////////////////////

    ctr_counter_unit counter_unit_i (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .init_ctr  (init_ctr),
        .data_in   (data_in),
        .key       (key),
        .blk_valid (blk_valid),
        .blk_ctr   (blk_ctr),
        .blk_key   (blk_key),
        .blk_data  (blk_data),
        .err       (err)
    );

    ////////////////////////////////////////////////////////////
    // Keystream pipeline
    ////////////////////////////////////////////////////////////

    ctr_keystream keystream_i (
        .clk       (clk),
        .reset     (reset),
        .blk_valid (blk_valid),
        .blk_ctr   (blk_ctr),
        .blk_key   (blk_key),
        .blk_data  (blk_data),
        .ks_valid  (ks_valid),
        .ks_word   (ks_word),
        .ks_data   (ks_data)
    );

    // Final XOR and output register
    ctr_combiner combiner_i (
        .clk        (clk),
        .reset      (reset),
        .ks_valid   (ks_valid),
        .ks_word    (ks_word),
        .ks_data    (ks_data),
        .data_out   (data_out),
        .data_valid (data_valid)
    );

endmodule

`default_nettype wire

// File: tb_ctr_cipher.sv
// Expects default macros; run ends at the first mismatch and is capped at MAX_CYCLES clock cycles
`timescale 1ns/1ps
`default_nettype none

`include "ctr_cipher_defs.svh"

module tb_ctr_cipher import ctr_cipher_pkg::*; ();

    // Sampling edge to observed data_valid
    localparam int LATENCY    = `CTR_KS_ROUNDS + 2;
    // About 150 cycles of tests, rest is margin
    localparam int MAX_CYCLES = 400;
    localparam int NEVER      = 2147483647;
    localparam int N_BLOCKS   = 20;

    logic  clk;
    logic  reset;
    logic  cmd_valid;
    cmd_e  cmd;
    ctr_t  init_ctr;
    word_t data_in;
    word_t key;
    word_t data_out;
    logic  data_valid;
    logic  err;

    int    cycle = 0;
    int    err_from = NEVER;
    word_t rng = 32'h1338faeb;
    string test_name = "reset_idle";
    // Reference model of the counter unit
    ctr_t  model_ctr = '0;
    logic  model_loaded = 1'b0;
    // Scoreboard, expected word plus the cycle it is due
    word_t sb_word [$];
    int    sb_due [$];
    // Expectations for the next edge, updated on the falling edge
    logic  exp_valid = 1'b0;
    logic  exp_err = 1'b0;
    word_t exp_word = '0;
    // Round trip material
    logic  capture_on = 1'b0;
    word_t ct_q [$];
    word_t pt_q [$];
    word_t key_q [$];

    ctr_cipher_top dut_i (
        .clk        (clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .init_ctr   (init_ctr),
        .data_in    (data_in),
        .key        (key),
        .data_out   (data_out),
        .data_valid (data_valid),
        .err        (err)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    ////////////////////////////////////////////////////////////
    // Reference model and helpers
    ////////////////////////////////////////////////////////////

    function automatic word_t lcg_next();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    // Add, rotate left, xor with byte-rotated key, per round
    function automatic word_t keystream_model(input ctr_t c, input word_t k);
        word_t state;
        word_t sum;
        state = {c, ~c};
        for (int i = 0; i < `CTR_KS_ROUNDS; i++) begin
            sum   = state + k;
            state = word_t'({sum, sum} >> (`CTR_DATA_WIDTH - `CTR_KS_ROT))
                  ^ word_t'({k, k} >> ((8 * i) % `CTR_DATA_WIDTH));
        end
        return state;
    endfunction

    task automatic stop_with_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped on failure");
    endtask

    task automatic value_error(input string what, input word_t expv, input word_t actv);
        $display("ERROR %s %s: expected %h actual %h", test_name, what, expv, actv);
        stop_with_failure();
    endtask

    ////////////////////////////////////////////////////////////
    // Scoreboard and checks
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        exp_valid = (sb_due.size() > 0) && (sb_due[0] == cycle);
        exp_word  = exp_valid ? sb_word[0] : '0;
        exp_err   = (cycle >= err_from);
        // Ciphertexts kept for the round trip
        if (capture_on && data_valid) ct_q.push_back(data_out);
    end

    always @(posedge clk) begin
        if (exp_valid) begin
            sb_word.pop_front();
            sb_due.pop_front();
        end
        if (cycle >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles in test %s", MAX_CYCLES, test_name);
            stop_with_failure();
        end
    end

    a_valid_check: assert property (@(posedge clk) disable iff (reset)
        data_valid == exp_valid)
        else value_error("data_valid", word_t'(exp_valid), word_t'($sampled(data_valid)));

    a_data_check: assert property (@(posedge clk) disable iff (reset)
        exp_valid |-> data_out == exp_word)
        else value_error("data_out", exp_word, $sampled(data_out));

    a_err_check: assert property (@(posedge clk) disable iff (reset)
        err == exp_err)
        else value_error("err", word_t'(exp_err), word_t'($sampled(err)));

    ////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////

    task automatic note_err();
        if (err_from == NEVER) err_from = cycle + 2;
    endtask

    // Drives one command and updates the model with it
    task automatic send_cmd(input cmd_e c, input ctr_t ic, input word_t d, input word_t k,
                            input word_t expv);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd       <= c;
        init_ctr  <= ic;
        data_in   <= d;
        key       <= k;
        case (c)
            CMD_LOAD: begin
                model_ctr    = ic;
                model_loaded = 1'b1;
            end
            CMD_PROCESS: begin
                if (model_loaded) begin
                    sb_word.push_back(expv);
                    sb_due.push_back(cycle + 1 + LATENCY);
                    model_ctr = model_ctr + 16'd1;
                end else begin
                    note_err();
                end
            end
            CMD_RESERVED: note_err();
            default: begin
            end
        endcase
    endtask

    task automatic process_block(input word_t d, input word_t k);
        send_cmd(CMD_PROCESS, '0, d, k, d ^ keystream_model(model_ctr, k));
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            cmd_valid <= 1'b0;
        end
    endtask

    task automatic wait_drain();
        idle(1);
        while (sb_word.size() > 0) @(posedge clk);
        idle(2);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset        <= 1'b1;
        cmd_valid    <= 1'b0;
        err_from     = NEVER;
        model_loaded = 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        word_t d;
        word_t k;
        reset     <= 1'b1;
        cmd_valid <= 1'b0;
        cmd       <= CMD_NOP;
        init_ctr  <= '0;
        data_in   <= '0;
        key       <= '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // Only idle commands, nothing may come out
        for (int i = 0; i < 8; i++) send_cmd(CMD_NOP, '0, '0, '0, '0);
        idle(4);

        // Block before any load is dropped
        test_name = "process_unloaded";
        apply_reset();
        d = lcg_next();
        k = lcg_next();
        process_block(d, k);
        idle(10);

        test_name = "reserved_opcode";
        apply_reset();
        send_cmd(CMD_RESERVED, '0, lcg_next(), lcg_next(), '0);
        idle(6);

        // One block, latency checked by the due cycle
        test_name = "single_block";
        apply_reset();
        d = lcg_next();
        send_cmd(CMD_LOAD, d[15:0], '0, '0, '0);
        process_block(lcg_next(), lcg_next());
        wait_drain();

        // Back to back across the counter wrap
        test_name = "burst_wrap";
        send_cmd(CMD_LOAD, 16'hfffe, '0, '0, '0);
        capture_on = 1'b1;
        for (int i = 0; i < N_BLOCKS; i++) begin
            d = lcg_next();
            k = lcg_next();
            pt_q.push_back(d);
            key_q.push_back(k);
            process_block(d, k);
        end
        wait_drain();
        capture_on = 1'b0;

        // Same counters and keys turn ciphertext back into plaintext
        test_name = "round_trip";
        if (ct_q.size() != N_BLOCKS) begin
            $display("Captured %0d ciphertexts instead of %0d", ct_q.size(), N_BLOCKS);
            stop_with_failure();
        end
        send_cmd(CMD_LOAD, 16'hfffe, '0, '0, '0);
        for (int i = 0; i < N_BLOCKS; i++) begin
            send_cmd(CMD_PROCESS, '0, ct_q[i], key_q[i], pt_q[i]);
        end
        wait_drain();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
ctr_cipher_pkg.sv
ctr_counter_unit.sv
ctr_keystream.sv
ctr_combiner.sv
ctr_cipher_top.sv
tb_ctr_cipher.sv

// File: Makefile
# Verilator build and run for the counter-mode cipher testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_ctr_cipher
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

# Exit status of the simulation is the test result
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
